// ==== hw/pipe_defs.svh ====
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

`default_nettype none

// machine word, also register width
`define DATA_W 32

// architectural registers, dest field is log2 of this
`define RF_NUM 32

// data ram depth in words
// byte addresses wrap modulo the depth
`define DRAM_WORDS 256

`default_nettype wire

`endif

// ==== hw/pipe_pkg.sv ====
`include "pipe_defs.svh"
`default_nettype none

package pipe_pkg;

    // register index width
    localparam int RF_AW = $clog2(`RF_NUM);
    // ram word index width
    localparam int DRAM_AW = $clog2(`DRAM_WORDS);

    // memory access kind carried down the pipe
    typedef enum logic [3:0] {
        MOP_NONE,
        MOP_LW,
        MOP_LB,
        MOP_LBU,
        MOP_LH,
        MOP_LHU,
        MOP_SW,
        MOP_SB,
        MOP_SH
    } mem_op_e;

    // execute to memory
    typedef struct packed {
        logic              ex;
        logic              gr_we;
        logic [RF_AW-1:0]  dest;
        mem_op_e           mem_op;
        // alu result or effective address
        logic [`DATA_W-1:0] result;
        // store data
        logic [`DATA_W-1:0] rt_value;
        logic [`DATA_W-1:0] pc;
    } es_to_ms_t;

    // memory to write-back
    typedef struct packed {
        logic              ex;
        logic              gr_we;
        logic [RF_AW-1:0]  dest;
        mem_op_e           mem_op;
        logic [1:0]        byte_off;
        logic [`DATA_W-1:0] result;
        // raw ram word, lanes not yet picked
        logic [`DATA_W-1:0] rdata;
        logic [`DATA_W-1:0] pc;
    } ms_to_ws_t;

    // write port of the register file
    typedef struct packed {
        logic              we;
        logic [RF_AW-1:0]  waddr;
        logic [`DATA_W-1:0] wdata;
    } ws_to_rf_t;

    // trace port, rf_wen is four copies of we
    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        logic [3:0]        rf_wen;
        logic [RF_AW-1:0]  rf_wnum;
        logic [`DATA_W-1:0] rf_wdata;
    } debug_wb_t;

endpackage

`default_nettype wire

// ==== hw/data_ram.sv ====
`timescale 1ns/1ns
`include "pipe_defs.svh"
`default_nettype none

module data_ram (
    input  logic                         clk,
    input  logic                         en,
    input  logic [3:0]                   we,
    input  logic [pipe_pkg::DRAM_AW-1:0] addr,
    input  logic [`DATA_W-1:0]           wdata,
    output logic [`DATA_W-1:0]           rdata
);

    // word array, contents undefined until written
    logic [`DATA_W-1:0] mem [`DRAM_WORDS];

    always_ff @(posedge clk) begin
        if (en) begin
            // one enable per byte lane
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
            // read-before-write, old word comes back
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ns
`include "pipe_defs.svh"
`default_nettype none

module mem_stage (
    input  logic                         clk,
    input  logic                         reset,
    // from execute
    input  logic                         es_to_ms_valid,
    input  pipe_pkg::es_to_ms_t          es_to_ms_bus,
    output logic                         ms_allowin,
    // to write-back
    output logic                         ms_to_ws_valid,
    output pipe_pkg::ms_to_ws_t          ms_to_ws_bus,
    input  logic                         ws_allowin,
    // data ram request
    output logic                         ram_en,
    output logic [3:0]                   ram_we,
    output logic [pipe_pkg::DRAM_AW-1:0] ram_addr,
    output logic [`DATA_W-1:0]           ram_wdata,
    input  logic [`DATA_W-1:0]           ram_rdata
);

    import pipe_pkg::*;

    logic      ms_valid;
    logic      ms_ready_go;
    logic      accept;
    es_to_ms_t ms_bus_r;
    logic [1:0] in_off;
    logic [3:0] store_lanes;

    // no wait states here, ram answers in one cycle
    assign ms_ready_go    = 1'b1;
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;
    assign accept         = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            ms_bus_r <= es_to_ms_bus;
        end
    end

    // byte offset of the incoming address
    assign in_off = es_to_ms_bus.result[1:0];

    // lane mask per store width
    always_comb begin
        unique case (es_to_ms_bus.mem_op)
            MOP_SW:  store_lanes = 4'b1111;
            MOP_SB:  store_lanes = 4'b0001 << in_off;
            MOP_SH:  store_lanes = in_off[1] ? 4'b1100 : 4'b0011;
            default: store_lanes = 4'b0000;
        endcase
    end

    // request goes out on the accept edge using the incoming bus
    assign ram_en   = accept;
    assign ram_addr = es_to_ms_bus.result[2 +: DRAM_AW];
    // excepting instructions never touch memory
    assign ram_we   = (accept && !es_to_ms_bus.ex) ? store_lanes : 4'b0000;

    // replicate store data across lanes, the mask picks the live ones
    always_comb begin
        unique case (es_to_ms_bus.mem_op)
            MOP_SB:  ram_wdata = {4{es_to_ms_bus.rt_value[7:0]}};
            MOP_SH:  ram_wdata = {2{es_to_ms_bus.rt_value[15:0]}};
            default: ram_wdata = es_to_ms_bus.rt_value;
        endcase
    end

    // registered fields plus the live ram word
    always_comb begin
        ms_to_ws_bus.ex       = ms_bus_r.ex;
        ms_to_ws_bus.gr_we    = ms_bus_r.gr_we;
        ms_to_ws_bus.dest     = ms_bus_r.dest;
        ms_to_ws_bus.mem_op   = ms_bus_r.mem_op;
        ms_to_ws_bus.byte_off = ms_bus_r.result[1:0];
        ms_to_ws_bus.result   = ms_bus_r.result;
        ms_to_ws_bus.rdata    = ram_rdata;
        ms_to_ws_bus.pc       = ms_bus_r.pc;
    end

endmodule

`default_nettype wire

// ==== hw/wb_stage.sv ====
`timescale 1ns/1ns
`include "pipe_defs.svh"
`default_nettype none

module wb_stage (
    input  logic                       clk,
    input  logic                       reset,
    // from memory stage
    input  logic                       ms_to_ws_valid,
    input  pipe_pkg::ms_to_ws_t        ms_to_ws_bus,
    output logic                       ws_allowin,
    // register file write port
    output pipe_pkg::ws_to_rf_t        ws_to_rf,
    // trace port
    output pipe_pkg::debug_wb_t        debug_wb,
    // bypass toward decode
    output logic [pipe_pkg::RF_AW-1:0] wb_dest,
    output logic [`DATA_W-1:0]         wb_result,
    // one-cycle pulses to the counters
    output logic                       retire,
    output logic                       squash
);

    import pipe_pkg::*;

    logic               ws_valid;
    logic               ws_ready_go;
    ms_to_ws_t          ws_bus_r;
    logic [7:0]         load_byte;
    logic [15:0]        load_half;
    logic [`DATA_W-1:0] final_result;
    logic               rf_we;

    assign ws_ready_go = 1'b1;
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    // captures the ram word while it is still live
    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus_r <= ms_to_ws_bus;
        end
    end

    // byte at the offset, half picked by offset bit 1
    assign load_byte = ws_bus_r.rdata[{ws_bus_r.byte_off, 3'b000} +: 8];
    assign load_half = ws_bus_r.byte_off[1] ? ws_bus_r.rdata[31:16] : ws_bus_r.rdata[15:0];

    always_comb begin
        unique case (ws_bus_r.mem_op)
            MOP_LW:  final_result = ws_bus_r.rdata;
            MOP_LB:  final_result = {{(`DATA_W-8){load_byte[7]}}, load_byte};
            MOP_LBU: final_result = {{(`DATA_W-8){1'b0}}, load_byte};
            MOP_LH:  final_result = {{(`DATA_W-16){load_half[15]}}, load_half};
            MOP_LHU: final_result = {{(`DATA_W-16){1'b0}}, load_half};
            // alu ops and stores pass result through
            default: final_result = ws_bus_r.result;
        endcase
    end

    // exceptional instructions are squashed here
    assign rf_we = ws_valid && ws_bus_r.gr_we && !ws_bus_r.ex;

    assign ws_to_rf.we    = rf_we;
    assign ws_to_rf.waddr = ws_bus_r.dest;
    assign ws_to_rf.wdata = final_result;

    assign debug_wb.pc       = ws_bus_r.pc;
    assign debug_wb.rf_wen   = {4{rf_we}};
    assign debug_wb.rf_wnum  = ws_bus_r.dest;
    assign debug_wb.rf_wdata = final_result;

    // dest masked so decode ignores an empty stage
    assign wb_dest   = ws_bus_r.dest & {RF_AW{ws_valid}};
    assign wb_result = final_result;

    assign retire = ws_valid && !ws_bus_r.ex;
    assign squash = ws_valid && ws_bus_r.ex;

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ns
`include "pipe_defs.svh"
`default_nettype none

module regfile (
    input  logic                       clk,
    input  logic                       reset,
    input  pipe_pkg::ws_to_rf_t        ws_to_rf,
    input  logic [pipe_pkg::RF_AW-1:0] raddr1,
    input  logic [pipe_pkg::RF_AW-1:0] raddr2,
    output logic [`DATA_W-1:0]         rdata1,
    output logic [`DATA_W-1:0]         rdata2
);

    import pipe_pkg::*;

    logic [`DATA_W-1:0] regs [`RF_NUM];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RF_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (ws_to_rf.we && ws_to_rf.waddr != RF_AW'(0)) begin
            // r0 stays zero
            regs[ws_to_rf.waddr] <= ws_to_rf.wdata;
        end
    end

    // no internal bypass, old value seen in the write cycle
    // decode forwards via wb_dest/wb_result instead
    assign rdata1 = (raddr1 == RF_AW'(0)) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == RF_AW'(0)) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== hw/retire_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module retire_counter (
    input  logic        clk,
    input  logic        reset,
    input  logic        retire,
    input  logic        squash,
    output logic [31:0] retired_count,
    output logic [31:0] squashed_count
);

    // slot 0 retired, slot 1 squashed
    logic [1:0]  bump;
    logic [31:0] cnt [2];

    assign bump = {squash, retire};

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt[0] <= '0;
            cnt[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                // hold at all ones, no wrap
                if (bump[i] && cnt[i] != '1) begin
                    cnt[i] <= cnt[i] + 32'd1;
                end
            end
        end
    end

    assign retired_count  = cnt[0];
    assign squashed_count = cnt[1];

endmodule

`default_nettype wire

// ==== hw/pipe_tail_top.sv ====
`timescale 1ns/1ns
`include "pipe_defs.svh"
`default_nettype none

module pipe_tail_top (
    input  logic                       clk,
    input  logic                       reset,
    // execute result in
    input  logic                       es_to_ms_valid,
    input  pipe_pkg::es_to_ms_t        es_to_ms_bus,
    output logic                       ms_allowin,
    // register read ports for decode
    input  logic [pipe_pkg::RF_AW-1:0] raddr1,
    input  logic [pipe_pkg::RF_AW-1:0] raddr2,
    output logic [`DATA_W-1:0]         rdata1,
    output logic [`DATA_W-1:0]         rdata2,
    // trace and bypass
    output pipe_pkg::debug_wb_t        debug_wb,
    output logic [pipe_pkg::RF_AW-1:0] wb_dest,
    output logic [`DATA_W-1:0]         wb_result,
    // perf counters
    output logic [31:0]                retired_count,
    output logic [31:0]                squashed_count
);

    import pipe_pkg::*;

    logic               ms_to_ws_valid;
    ms_to_ws_t          ms_to_ws_bus;
    logic               ws_allowin;
    ws_to_rf_t          ws_to_rf;
    logic               retire;
    logic               squash;

    // ram request/response
    logic               ram_en;
    logic [3:0]         ram_we;
    logic [DRAM_AW-1:0] ram_addr;
    logic [`DATA_W-1:0] ram_wdata;
    logic [`DATA_W-1:0] ram_rdata;

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .ram_rdata      (ram_rdata)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .ws_to_rf       (ws_to_rf),
        .debug_wb       (debug_wb),
        .wb_dest        (wb_dest),
        .wb_result      (wb_result),
        .retire         (retire),
        .squash         (squash)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .ws_to_rf (ws_to_rf),
        .raddr1   (raddr1),
        .raddr2   (raddr2),
        .rdata1   (rdata1),
        .rdata2   (rdata2)
    );

    retire_counter u_retire_counter (
        .clk            (clk),
        .reset          (reset),
        .retire         (retire),
        .squash         (squash),
        .retired_count  (retired_count),
        .squashed_count (squashed_count)
    );

endmodule

`default_nettype wire

// ==== verif/pipe_tail_assert.sv ====
`timescale 1ns/1ns
`include "pipe_defs.svh"
`default_nettype none

module pipe_tail_assert (
    input logic                       clk,
    input logic                       reset,
    input logic                       es_to_ms_valid,
    input pipe_pkg::es_to_ms_t        es_to_ms_bus,
    input logic                       ms_allowin,
    input pipe_pkg::debug_wb_t        debug_wb,
    input pipe_pkg::ws_to_rf_t        ws_to_rf,
    input logic [pipe_pkg::RF_AW-1:0] wb_dest
);

    // read by the testbench summary
    int fail_count = 0;

    // upstream transfer, lands in write-back two edges later
    logic accept;
    logic accept_wr;
    logic accept_ex;

    assign accept    = es_to_ms_valid && ms_allowin;
    assign accept_wr = accept && es_to_ms_bus.gr_we && !es_to_ms_bus.ex;
    assign accept_ex = accept && es_to_ms_bus.ex;

    // trace lanes all follow the write owed by the accepted instruction
    rf_wen_uniform: assert property (@(posedge clk) disable iff (reset)
        debug_wb.rf_wen == ($past(accept_wr, 2) ? 4'b1111 : 4'b0000))
        else begin
            $error("debug rf_wen lanes wrong: %b", debug_wb.rf_wen);
            fail_count++;
        end

    // ex flagged upstream, no register write two edges on
    no_write_on_ex: assert property (@(posedge clk) disable iff (reset)
        $past(accept_ex, 2) |-> !ws_to_rf.we)
        else begin
            $error("register write issued for an excepting instruction");
            fail_count++;
        end

    // nothing accepted two edges back, write-back empty, no bypass target
    dest_zero_idle: assert property (@(posedge clk) disable iff (reset)
        !$past(accept, 2) |-> wb_dest == '0)
        else begin
            $error("wb_dest nonzero with write-back empty: %0d", wb_dest);
            fail_count++;
        end

    // no back-pressure anywhere
    allowin_high: assert property (@(posedge clk) disable iff (reset) ms_allowin)
        else begin
            $error("ms_allowin dropped low");
            fail_count++;
        end

endmodule

bind pipe_tail_top pipe_tail_assert u_assert (
    .clk            (clk),
    .reset          (reset),
    .es_to_ms_valid (es_to_ms_valid),
    .es_to_ms_bus   (es_to_ms_bus),
    .ms_allowin     (ms_allowin),
    .debug_wb       (debug_wb),
    .ws_to_rf       (ws_to_rf),
    .wb_dest        (wb_dest)
);

`default_nettype wire

// ==== verif/pipe_tail_tb.sv ====
`timescale 1ns/1ns
`include "pipe_defs.svh"
`default_nettype none

module pipe_tail_tb;

    import pipe_pkg::*;

    localparam logic [31:0] SEED = 32'h8ae5;
    // ram words touched by the tests
    localparam int WIN = 16;
    // stimulus needs about 250 cycles, bound is generous
    localparam int STIM_CYCLES = 400;
    localparam int TIMEOUT_NS  = STIM_CYCLES * 10 * 5;

    // what write-back should show for one issue slot
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [4:0]  dest;
        logic [31:0] wdata;
        logic [31:0] pc;
    } wb_exp_t;

    logic               clk;
    logic               reset;
    logic               es_to_ms_valid;
    es_to_ms_t          es_to_ms_bus;
    logic               ms_allowin;
    logic [RF_AW-1:0]   raddr1;
    logic [RF_AW-1:0]   raddr2;
    logic [`DATA_W-1:0] rdata1;
    logic [`DATA_W-1:0] rdata2;
    debug_wb_t          debug_wb;
    logic [RF_AW-1:0]   wb_dest;
    logic [`DATA_W-1:0] wb_result;
    logic [31:0]        retired_count;
    logic [31:0]        squashed_count;

    // shadow state of the model
    logic [31:0] shadow_ram [`DRAM_WORDS];
    logic [31:0] shadow_rf [`RF_NUM];
    wb_exp_t     exp_q [$];
    int          errors;
    int          exp_retired;
    int          exp_squashed;
    logic [31:0] pc_next;
    string       test_name;

    pipe_tail_top dut (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .raddr1         (raddr1),
        .raddr2         (raddr2),
        .rdata1         (rdata1),
        .rdata2         (rdata2),
        .debug_wb       (debug_wb),
        .wb_dest        (wb_dest),
        .wb_result      (wb_result),
        .retired_count  (retired_count),
        .squashed_count (squashed_count)
    );

    always #5 clk = ~clk;

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] byte_addr(input int w, input int off);
        return 32'(w * 4 + off);
    endfunction

    // prefill value, spread over the whole word index
    function automatic logic [31:0] fill_word(input int w);
        return (32'(w) * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(31, 1));
    endfunction

    task automatic check_val(input string what, input logic [31:0] expv,
                             input logic [31:0] actv);
        assert (actv === expv) else begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test_name, what, expv, actv);
        end
    endtask

    // model of one instruction, run in program order at issue
    task automatic apply_model(input logic v, input es_to_ms_t ins, output wb_exp_t e);
        logic [DRAM_AW-1:0] widx;
        logic [1:0]         off;
        logic [31:0]        word;
        logic [7:0]         b;
        logic [15:0]        h;
        widx = ins.result[2 +: DRAM_AW];
        off  = ins.result[1:0];
        word = shadow_ram[widx];
        b    = word[8*off +: 8];
        h    = off[1] ? word[31:16] : word[15:0];
        e.valid = v;
        e.we    = v && ins.gr_we && !ins.ex;
        e.dest  = ins.dest;
        e.pc    = ins.pc;
        case (ins.mem_op)
            MOP_LW:  e.wdata = word;
            MOP_LB:  e.wdata = {{24{b[7]}}, b};
            MOP_LBU: e.wdata = {24'h0, b};
            MOP_LH:  e.wdata = {{16{h[15]}}, h};
            MOP_LHU: e.wdata = {16'h0, h};
            default: e.wdata = ins.result;
        endcase
        if (v && !ins.ex) begin
            // only clean stores reach memory
            case (ins.mem_op)
                MOP_SW:  shadow_ram[widx] = ins.rt_value;
                MOP_SB:  shadow_ram[widx][8*off +: 8] = ins.rt_value[7:0];
                MOP_SH:  shadow_ram[widx][16*off[1] +: 16] = ins.rt_value[15:0];
                default: ;
            endcase
            exp_retired++;
        end else if (v) begin
            exp_squashed++;
        end
        // r0 never changes
        if (e.we && e.dest != 5'd0) begin
            shadow_rf[e.dest] = e.wdata;
        end
    endtask

    task automatic check_wb(input wb_exp_t e);
        check_val("rf_wen", {28'h0, {4{e.we}}}, {28'h0, debug_wb.rf_wen});
        check_val("wb_dest", e.valid ? {27'h0, e.dest} : 32'h0, {27'h0, wb_dest});
        if (e.valid) begin
            check_val("pc", e.pc, debug_wb.pc);
        end
        if (e.we) begin
            check_val("rf_wnum", {27'h0, e.dest}, {27'h0, debug_wb.rf_wnum});
            check_val("rf_wdata", e.wdata, debug_wb.rf_wdata);
            check_val("wb_result", e.wdata, wb_result);
        end
    endtask

    // one issue slot per falling edge
    task automatic step(input logic v, input es_to_ms_t ins);
        wb_exp_t e;
        @(negedge clk);
        // slot issued two edges back sits in write-back now
        if (exp_q.size() == 2) begin
            check_wb(exp_q.pop_front());
        end
        es_to_ms_valid = v;
        es_to_ms_bus   = ins;
        apply_model(v, ins, e);
        exp_q.push_back(e);
    endtask

    task automatic issue(input mem_op_e op, input logic ex, input logic gr_we,
                         input logic [4:0] dest, input logic [31:0] res,
                         input logic [31:0] rt);
        es_to_ms_t ins;
        ins.ex       = ex;
        ins.gr_we    = gr_we;
        ins.dest     = dest;
        ins.mem_op   = op;
        ins.result   = res;
        ins.rt_value = rt;
        ins.pc       = pc_next;
        pc_next      = pc_next + 32'd4;
        step(1'b1, ins);
    endtask

    task automatic bubble();
        step(1'b0, '0);
    endtask

    initial begin
        int w;
        clk            = 1'b0;
        reset          = 1'b1;
        es_to_ms_valid = 1'b0;
        es_to_ms_bus   = '0;
        raddr1         = '0;
        raddr2         = '0;
        errors         = 0;
        exp_retired    = 0;
        exp_squashed   = 0;
        pc_next        = 32'hbfc0_0000;
        void'($urandom(SEED));
        for (int r = 0; r < `RF_NUM; r++) begin
            shadow_rf[r] = 32'h0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // idle after reset
        test_name = "reset_idle";
        @(negedge clk);
        check_val("rf_wen", 32'h0, {28'h0, debug_wb.rf_wen});
        check_val("wb_dest", 32'h0, {27'h0, wb_dest});
        check_val("retired_count", 32'h0, retired_count);
        check_val("squashed_count", 32'h0, squashed_count);

        test_name = "prefill";
        for (int i = 0; i < WIN; i++) begin
            issue(MOP_SW, 1'b0, 1'b0, 5'd0, byte_addr(i, 0), fill_word(i));
        end

        // gaps of 0, 1 or 2 bubbles
        test_name = "sw_lw";
        for (int i = 0; i < 6; i++) begin
            w = int'($urandom_range(WIN - 1));
            issue(MOP_SW, 1'b0, 1'b0, 5'd0, byte_addr(w, 0), $urandom());
            repeat (i % 3) bubble();
            issue(MOP_LW, 1'b0, 1'b1, rand_reg(), byte_addr(w, 0), 32'h0);
        end

        test_name = "sub_word";
        for (int round = 0; round < 3; round++) begin
            for (int off = 0; off < 4; off++) begin
                w = int'($urandom_range(WIN - 1));
                issue(MOP_SB, 1'b0, 1'b0, 5'd0, byte_addr(w, off), $urandom());
                issue(MOP_LB, 1'b0, 1'b1, rand_reg(), byte_addr(w, off), 32'h0);
                issue(MOP_LBU, 1'b0, 1'b1, rand_reg(), byte_addr(w, off), 32'h0);
                if (off % 2 == 0) begin
                    issue(MOP_SH, 1'b0, 1'b0, 5'd0, byte_addr(w, off), $urandom());
                    issue(MOP_LH, 1'b0, 1'b1, rand_reg(), byte_addr(w, off), 32'h0);
                    issue(MOP_LHU, 1'b0, 1'b1, rand_reg(), byte_addr(w, off), 32'h0);
                end
            end
        end

        // some to r0, some with gr_we low
        test_name = "alu";
        for (int i = 0; i < 40; i++) begin
            issue(MOP_NONE, 1'b0, (i % 8) != 7, (i % 10 == 0) ? 5'd0 : rand_reg(),
                  $urandom(), 32'h0);
        end

        test_name = "exception";
        w = 3;
        issue(MOP_SW, 1'b1, 1'b0, 5'd0, byte_addr(w, 0), 32'hdead_beef);
        issue(MOP_SB, 1'b1, 1'b0, 5'd0, byte_addr(w, 1), 32'h0000_00a5);
        // misaligned half, flagged upstream
        issue(MOP_SH, 1'b1, 1'b0, 5'd0, byte_addr(w, 1), 32'h0000_5a5a);
        issue(MOP_NONE, 1'b1, 1'b1, 5'd7, 32'h1234_5678, 32'h0);
        issue(MOP_LW, 1'b1, 1'b1, 5'd9, byte_addr(w, 0), 32'h0);
        issue(MOP_LW, 1'b0, 1'b1, 5'd10, byte_addr(w, 0), 32'h0);
        issue(MOP_LHU, 1'b0, 1'b1, 5'd11, byte_addr(w, 2), 32'h0);
        repeat (2) bubble();

        test_name = "reg_readback";
        for (int r = 0; r < 16; r++) begin
            @(negedge clk);
            raddr1 = 5'(r);
            raddr2 = 5'(r + 16);
            @(posedge clk);
            check_val("rdata1", shadow_rf[r], rdata1);
            check_val("rdata2", shadow_rf[r + 16], rdata2);
        end

        test_name = "counters";
        @(negedge clk);
        check_val("retired_count", 32'(exp_retired), retired_count);
        check_val("squashed_count", 32'(exp_squashed), squashed_count);

        $display("summary: %0d check errors, %0d assertion failures",
                 errors, dut.u_assert.fail_count);
        if (errors == 0 && dut.u_assert.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hw
hw/pipe_pkg.sv
hw/data_ram.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/regfile.sv
hw/retire_counter.sv
hw/pipe_tail_top.sv
verif/pipe_tail_assert.sv
verif/pipe_tail_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pipe_tail_tb -f files.f

# keep running past assertion errors so the testbench can report them
./obj_dir/Vpipe_tail_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
